// File: hdl/cnnSettings.svh
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

// Image is square, scanned in raster order
`define IMAGE_SIZE 64

// Pixels and results are signed fixed point
`define DATA_WIDTH 20
`define FRAC_BITS 16

// Result address is row * IMAGE_SIZE + column
`define ADDR_WIDTH 12

// Shared bias of both kernels
`define BIAS_VALUE 20'hF7295

// 3x3 window
`define TAP_COUNT 9

// Result words buffered ahead of the result port
`define FIFO_DEPTH 4

`endif

// File: hdl/convPkg.sv
`include "cnnSettings.svh"

package convPkg;

    typedef logic signed [`DATA_WIDTH-1:0] pixel_t;
    typedef logic signed [2*`DATA_WIDTH-1:0] product_t;

    // Row-major taps, top-left first
    localparam pixel_t kernel0Weights [`TAP_COUNT] = '{
        20'h0a89e, 20'h092d5, 20'h06d43,
        20'h01004, 20'hf8f71, 20'hf6e54,
        20'hfa6d7, 20'hfc834, 20'hfac19
    };

    localparam pixel_t kernel1Weights [`TAP_COUNT] = '{
        20'hfd855, 20'h02992, 20'hfc994,
        20'h050fd, 20'h02f20, 20'h0202d,
        20'h03bd7, 20'hfd369, 20'h05e68
    };

    typedef enum logic [2:0] {
        idle,
        accumulate,
        emit0,
        emit1,
        done
    } scanState_t;

endpackage

// File: hdl/busPkg.sv
`include "cnnSettings.svh"

package busPkg;

    // Seven bits so that -1 and IMAGE_SIZE fit for padded taps
    typedef struct packed {
        logic [6:0] row;
        logic [6:0] col;
    } pixelPos_t;

    typedef enum logic {
        layer0Kernel0,
        layer0Kernel1
    } kernelSel_t;

    typedef struct packed {
        kernelSel_t kernel;
        logic [`ADDR_WIDTH-1:0] addr;
        convPkg::pixel_t value;
    } resultWord_t;

    typedef enum logic [1:0] {
        idle,
        request,
        releaseAck
    } writerState_t;

endpackage

// File: hdl/windowScanner.sv
`timescale 1ns/1ps
`include "cnnSettings.svh"

module windowScanner (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    macStall,
    output logic [`ADDR_WIDTH-1:0]  imageAddr,
    output logic                    tapValid,
    output logic                    padded,
    output logic                    lastTap,
    output logic [3:0]              tapIndex,
    output busPkg::pixelPos_t       centre,
    output logic                    scanDone
);

    convPkg::scanState_t state;
    logic [3:0] tapCount;
    logic [6:0] rowOffset;
    logic [6:0] colOffset;
    busPkg::pixelPos_t neighbour;
    logic lastCentre;

    // Offsets of -1, 0, +1 in seven-bit two's complement
    always_comb
    begin
        if (tapCount < 4'd3)
            rowOffset = 7'h7f;
        else if (tapCount < 4'd6)
            rowOffset = 7'h00;
        else
            rowOffset = 7'h01;

        case (tapCount)
            4'd0, 4'd3, 4'd6: colOffset = 7'h7f;
            4'd1, 4'd4, 4'd7: colOffset = 7'h00;
            default:          colOffset = 7'h01;
        endcase
    end

    assign neighbour.row = centre.row + rowOffset;
    assign neighbour.col = centre.col + colOffset;

    // Both -1 and IMAGE_SIZE land at or above IMAGE_SIZE
    assign padded = (neighbour.row >= `IMAGE_SIZE) || (neighbour.col >= `IMAGE_SIZE);
    assign imageAddr = padded ? '0
                              : `ADDR_WIDTH'(neighbour.row * `IMAGE_SIZE + neighbour.col);

    assign lastCentre = (centre.row == `IMAGE_SIZE - 1) && (centre.col == `IMAGE_SIZE - 1);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= convPkg::idle;
            tapCount <= '0;
            centre   <= '0;
        end
        else
        begin
            case (state)
                convPkg::idle:
                begin
                    if (start)
                    begin
                        state    <= convPkg::accumulate;
                        tapCount <= '0;
                        centre   <= '0;
                    end
                end
                convPkg::accumulate:
                begin
                    if (!macStall)
                    begin
                        if (tapCount == `TAP_COUNT - 1)
                            state <= convPkg::emit0;
                        else
                            tapCount <= tapCount + 4'd1;
                    end
                end
                convPkg::emit0:
                begin
                    if (!macStall)
                        state <= convPkg::emit1;
                end
                convPkg::emit1:
                begin
                    if (!macStall)
                    begin
                        tapCount <= '0;
                        if (lastCentre)
                            state <= convPkg::done;
                        else
                        begin
                            state <= convPkg::accumulate;
                            // Raster order, wrap to next row
                            if (centre.col == `IMAGE_SIZE - 1)
                            begin
                                centre.col <= '0;
                                centre.row <= centre.row + 7'd1;
                            end
                            else
                                centre.col <= centre.col + 7'd1;
                        end
                    end
                end
                convPkg::done:
                    state <= convPkg::idle;
                default:
                    state <= convPkg::idle;
            endcase
        end
    end

    assign tapValid = (state == convPkg::accumulate);
    assign tapIndex = tapCount;
    assign lastTap  = tapValid && (tapCount == `TAP_COUNT - 1);
    assign scanDone = (state == convPkg::done);

endmodule

// File: hdl/kernelMac.sv
`timescale 1ns/1ps
`include "cnnSettings.svh"

module kernelMac (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tapValid,
    input  logic                 padded,
    input  logic                 lastTap,
    input  logic [3:0]           tapIndex,
    input  busPkg::pixelPos_t    centre,
    input  convPkg::pixel_t      imageData,
    output logic                 macStall,
    output logic                 pushValid,
    input  logic                 pushReady,
    output busPkg::resultWord_t  pushWord
);

    convPkg::scanState_t macState;
    convPkg::pixel_t pixel;
    convPkg::product_t product0;
    convPkg::product_t product1;
    convPkg::pixel_t acc0;
    convPkg::pixel_t acc1;
    convPkg::pixel_t biased;
    convPkg::pixel_t reluOut;
    logic [`ADDR_WIDTH-1:0] centreAddr;

    assign pixel    = padded ? '0 : imageData;
    assign product0 = pixel * convPkg::kernel0Weights[tapIndex];
    assign product1 = pixel * convPkg::kernel1Weights[tapIndex];

    // First tap restarts the sums, adds wrap at DATA_WIDTH
    always_ff @(posedge clk)
    begin
        if (tapValid)
        begin
            acc0 <= ((tapIndex == 4'd0) ? '0 : acc0)
                    + product0[`FRAC_BITS+`DATA_WIDTH-2:`FRAC_BITS-1];
            acc1 <= ((tapIndex == 4'd0) ? '0 : acc1)
                    + product1[`FRAC_BITS+`DATA_WIDTH-2:`FRAC_BITS-1];
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            macState <= convPkg::idle;
        else
        begin
            case (macState)
                convPkg::idle, convPkg::accumulate:
                begin
                    if (tapValid)
                        macState <= lastTap ? convPkg::emit0 : convPkg::accumulate;
                end
                convPkg::emit0:
                begin
                    if (pushReady)
                        macState <= convPkg::emit1;
                end
                convPkg::emit1:
                begin
                    if (pushReady)
                        macState <= convPkg::idle;
                end
                default:
                    macState <= convPkg::idle;
            endcase
        end
    end

    // Bias and ReLU on whichever kernel is being emitted
    assign biased  = ((macState == convPkg::emit0) ? acc0 : acc1)
                     + convPkg::pixel_t'(`BIAS_VALUE);
    assign reluOut = (biased > 0) ? biased : '0;

    assign centreAddr = `ADDR_WIDTH'(centre.row * `IMAGE_SIZE + centre.col);

    assign pushValid = (macState == convPkg::emit0) || (macState == convPkg::emit1);
    assign macStall  = pushValid && !pushReady;

    assign pushWord.kernel = (macState == convPkg::emit1) ? busPkg::layer0Kernel1
                                                          : busPkg::layer0Kernel0;
    assign pushWord.addr   = centreAddr;
    assign pushWord.value  = reluOut;

endmodule

// File: hdl/resultFifo.sv
`timescale 1ns/1ps
`include "cnnSettings.svh"

module resultFifo (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pushValid,
    output logic                 pushReady,
    input  busPkg::resultWord_t  pushWord,
    output logic                 popValid,
    input  logic                 popReady,
    output busPkg::resultWord_t  popWord
);

    localparam int ptrWidth = $clog2(`FIFO_DEPTH);

    busPkg::resultWord_t storage [`FIFO_DEPTH];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth:0] count;
    logic doPush;
    logic doPop;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        return (ptr == ptrWidth'(`FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pushReady = (count != (ptrWidth+1)'(`FIFO_DEPTH));
    assign popValid  = (count != '0);
    assign doPush    = pushValid && pushReady;
    assign doPop     = popValid && popReady;
    assign popWord   = storage[rdPtr];

    always_ff @(posedge clk)
    begin
        if (doPush)
            storage[wrPtr] <= pushWord;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= nextPtr(wrPtr);
            if (doPop)
                rdPtr <= nextPtr(rdPtr);
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/layerWriter.sv
`timescale 1ns/1ps

module layerWriter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 popValid,
    output logic                 popReady,
    input  busPkg::resultWord_t  popWord,
    input  logic                 scanDone,
    output logic                 resultReq,
    input  logic                 resultAck,
    output busPkg::resultWord_t  result,
    output logic                 drained
);

    busPkg::writerState_t state;
    logic scanSeen;

    // New word only once the previous ack is low
    assign popReady  = (state == busPkg::idle) && !resultAck;
    assign resultReq = (state == busPkg::request);
    assign drained   = scanSeen && (state == busPkg::idle) && !popValid;

    always_ff @(posedge clk)
    begin
        if (popValid && popReady)
            result <= popWord;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= busPkg::idle;
            scanSeen <= 1'b0;
        end
        else
        begin
            if (scanDone)
                scanSeen <= 1'b1;
            else if (drained)
                scanSeen <= 1'b0;

            case (state)
                busPkg::idle:
                    if (popValid && popReady)
                        state <= busPkg::request;
                busPkg::request:
                    if (resultAck)
                        state <= busPkg::releaseAck;
                busPkg::releaseAck:
                    if (!resultAck)
                        state <= busPkg::idle;
                default:
                    state <= busPkg::idle;
            endcase
        end
    end

endmodule

// File: hdl/convLayerTop.sv
`timescale 1ns/1ps
`include "cnnSettings.svh"

module convLayerTop (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ready,
    output logic                    busy,
    output logic [`ADDR_WIDTH-1:0]  imageAddr,
    input  convPkg::pixel_t         imageData,
    output logic                    resultReq,
    input  logic                    resultAck,
    output busPkg::resultWord_t     result
);

    logic start;
    logic macStall;
    logic tapValid;
    logic padded;
    logic lastTap;
    logic [3:0] tapIndex;
    busPkg::pixelPos_t centre;
    logic scanDone;
    logic pushValid;
    logic pushReady;
    busPkg::resultWord_t pushWord;
    logic popValid;
    logic popReady;
    busPkg::resultWord_t popWord;
    logic drained;

    // A run starts only from idle
    assign start = ready && !busy;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            busy <= 1'b0;
        else if (start)
            busy <= 1'b1;
        else if (drained)
            busy <= 1'b0;
    end

    windowScanner i_windowScanner (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .macStall  (macStall),
        .imageAddr (imageAddr),
        .tapValid  (tapValid),
        .padded    (padded),
        .lastTap   (lastTap),
        .tapIndex  (tapIndex),
        .centre    (centre),
        .scanDone  (scanDone)
    );

    kernelMac i_kernelMac (
        .clk       (clk),
        .reset     (reset),
        .tapValid  (tapValid),
        .padded    (padded),
        .lastTap   (lastTap),
        .tapIndex  (tapIndex),
        .centre    (centre),
        .imageData (imageData),
        .macStall  (macStall),
        .pushValid (pushValid),
        .pushReady (pushReady),
        .pushWord  (pushWord)
    );

    resultFifo i_resultFifo (
        .clk       (clk),
        .reset     (reset),
        .pushValid (pushValid),
        .pushReady (pushReady),
        .pushWord  (pushWord),
        .popValid  (popValid),
        .popReady  (popReady),
        .popWord   (popWord)
    );

    layerWriter i_layerWriter (
        .clk       (clk),
        .reset     (reset),
        .popValid  (popValid),
        .popReady  (popReady),
        .popWord   (popWord),
        .scanDone  (scanDone),
        .resultReq (resultReq),
        .resultAck (resultAck),
        .result    (result),
        .drained   (drained)
    );

endmodule

// File: dv/convLayerTb.sv
`timescale 1ns/1ps
`include "cnnSettings.svh"

module convLayerTb;

    localparam int clockPeriodNs = 4;
    localparam int timeoutCycles = 1000;
    localparam int pixelCount = `IMAGE_SIZE * `IMAGE_SIZE;

    logic clk;
    logic reset;
    logic ready;
    logic busy;
    logic [`ADDR_WIDTH-1:0] imageAddr;
    convPkg::pixel_t imageData;
    logic resultReq;
    logic resultAck;
    busPkg::resultWord_t result;

    integer seed;
    convPkg::pixel_t image [pixelCount];
    convPkg::pixel_t expected0 [pixelCount];
    convPkg::pixel_t expected1 [pixelCount];
    logic prevReq;
    busPkg::resultWord_t prevResult;

    convLayerTop i_convLayerTop (
        .clk       (clk),
        .reset     (reset),
        .ready     (ready),
        .busy      (busy),
        .imageAddr (imageAddr),
        .imageData (imageData),
        .resultReq (resultReq),
        .resultAck (resultAck),
        .result    (result)
    );

    // Combinational image memory
    assign imageData = image[imageAddr];

    always #(clockPeriodNs / 2) clk = ~clk;

    task automatic abortRun();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("FAIL at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
            abortRun();
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("ERROR: no %s within %0d clock cycles", what, timeoutCycles);
        abortRun();
    endtask

    task automatic waitForReq(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (resultReq !== level)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > timeoutCycles)
                reportTimeout(what);
        end
    endtask

    task automatic waitForBusy(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (busy !== level)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > timeoutCycles)
                reportTimeout(what);
        end
    endtask

    // Kind 0 gives random pixels, 1 a constant and 2 alternating signs
    task automatic fillImage(input int kind, input convPkg::pixel_t value);
        int row;
        int col;
        for (int addr = 0; addr < pixelCount; addr++)
        begin
            row = addr / `IMAGE_SIZE;
            col = addr % `IMAGE_SIZE;
            case (kind)
                0:       image[addr] = convPkg::pixel_t'($random(seed));
                1:       image[addr] = value;
                default: image[addr] = ((row + col) % 2 == 1) ? -value : value;
            endcase
        end
    endtask

    function automatic convPkg::pixel_t biasRelu(input convPkg::pixel_t sum);
        convPkg::pixel_t biased;
        biased = sum + convPkg::pixel_t'(`BIAS_VALUE);
        return (biased > 0) ? biased : '0;
    endfunction

    function automatic void buildExpected();
        int nRow;
        int nCol;
        convPkg::pixel_t pix;
        convPkg::product_t prod0;
        convPkg::product_t prod1;
        convPkg::pixel_t sum0;
        convPkg::pixel_t sum1;
        for (int row = 0; row < `IMAGE_SIZE; row++)
        begin
            for (int col = 0; col < `IMAGE_SIZE; col++)
            begin
                sum0 = '0;
                sum1 = '0;
                for (int tap = 0; tap < `TAP_COUNT; tap++)
                begin
                    nRow = row + tap / 3 - 1;
                    nCol = col + tap % 3 - 1;
                    // Zero padding outside the image
                    if (nRow < 0 || nRow >= `IMAGE_SIZE || nCol < 0 || nCol >= `IMAGE_SIZE)
                        pix = '0;
                    else
                        pix = image[nRow * `IMAGE_SIZE + nCol];
                    prod0 = pix * convPkg::kernel0Weights[tap];
                    prod1 = pix * convPkg::kernel1Weights[tap];
                    sum0 = sum0 + prod0[`FRAC_BITS+`DATA_WIDTH-2:`FRAC_BITS-1];
                    sum1 = sum1 + prod1[`FRAC_BITS+`DATA_WIDTH-2:`FRAC_BITS-1];
                end
                expected0[row * `IMAGE_SIZE + col] = biasRelu(sum0);
                expected1[row * `IMAGE_SIZE + col] = biasRelu(sum1);
            end
        end
    endfunction

    task automatic runCase(input int kind, input convPkg::pixel_t value, input int maxDelay);
        int delay;
        convPkg::pixel_t expectedValue;
        fillImage(kind, value);
        buildExpected();
        @(posedge clk);
        ready <= 1'b1;
        @(posedge clk);
        ready <= 1'b0;
        @(posedge clk);
        check("busy", busy, 1'b1);
        // Words arrive in raster order with kernel 0 first
        for (int pixelIndex = 0; pixelIndex < pixelCount; pixelIndex++)
        begin
            for (int kernelIndex = 0; kernelIndex < 2; kernelIndex++)
            begin
                waitForReq(1'b1, "rise of resultReq");
                check("busy", busy, 1'b1);
                check("result.kernel", result.kernel, kernelIndex);
                check("result.addr", result.addr, pixelIndex);
                expectedValue = (kernelIndex == 0) ? expected0[pixelIndex]
                                                   : expected1[pixelIndex];
                check("result.value", $unsigned(result.value), $unsigned(expectedValue));
                delay = $unsigned($random(seed)) % (maxDelay + 1);
                repeat (delay) @(posedge clk);
                resultAck <= 1'b1;
                waitForReq(1'b0, "drop of resultReq");
                // Ack stays high a while after the request drops
                delay = $unsigned($random(seed)) % (maxDelay + 1);
                repeat (delay)
                begin
                    check("busy", busy, 1'b1);
                    @(posedge clk);
                end
                check("busy", busy, 1'b1);
                resultAck <= 1'b0;
            end
        end
        waitForBusy(1'b0, "fall of busy after the last word");
        check("resultReq", resultReq, 1'b0);
    endtask

    // Four-phase rule on the result port
    always @(posedge clk)
    begin
        if (!reset && resultReq)
        begin
            if (!prevReq)
                check("resultAck at resultReq rise", resultAck, 1'b0);
            else
                check("result while resultReq high", result, prevResult);
        end
        prevReq <= resultReq;
        prevResult <= result;
    end

    initial
    begin
        int fd;
        int fields;
        int kind;
        int maxDelay;
        int caseCount;
        logic [31:0] value;
        string line;
        clk = 1'b0;
        reset = 1'b1;
        ready = 1'b0;
        resultAck = 1'b0;
        prevReq = 1'b0;
        prevResult = '0;
        seed = 32'h2c02_cb5c;
        caseCount = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check("busy", busy, 1'b0);
        check("resultReq", resultReq, 1'b0);

        fd = $fopen("dv/conv_cases.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open the case file dv/conv_cases.txt");
            abortRun();
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() > 0 && line[0] != "#")
            begin
                fields = $sscanf(line, "%d %h %d", kind, value, maxDelay);
                if (fields == 3)
                begin
                    runCase(kind, convPkg::pixel_t'(value), maxDelay);
                    caseCount++;
                end
                else if (fields > 0)
                begin
                    $display("ERROR: malformed line in the case file: %s", line);
                    abortRun();
                end
            end
        end
        $fclose(fd);

        if (caseCount < 2)
        begin
            $display("ERROR: only %0d cases read, at least two runs are needed", caseCount);
            abortRun();
        end
        else
        begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: dv/conv_cases.txt
# kind value maxDelay: kind 0 random, 1 constant, 2 alternating sign
# value is a hex Q4.16 pixel, maxDelay the largest ack delay in cycles
0 00000 0
1 10000 2
1 fc000 3
2 08000 1
1 00000 0
2 7ffff 5
0 00000 24

// File: sim.f
+incdir+hdl
hdl/convPkg.sv
hdl/busPkg.sv
hdl/windowScanner.sv
hdl/kernelMac.sv
hdl/resultFifo.sv
hdl/layerWriter.sv
hdl/convLayerTop.sv
dv/convLayerTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the convolution layer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module convLayerTb -f sim.f -o convLayerSim
./obj_dir/convLayerSim 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation finished without errors"
